/* verilog/mmio_params.svh */
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// ------------------------------
// Register offsets, lower page
// ------------------------------
`define MMIO_CFG_VPD_ID         7'h00   // Product id
`define MMIO_CFG_VPD_VER        7'h01
`define MMIO_CFG_VPD_REV        7'h02
`define MMIO_PHY_STAT           7'h10   // Read-only status bits
`define MMIO_PHY_ETH0           7'h11   // Three tuning bytes
`define MMIO_LY2_MAC0           7'h22   // Six bytes LSB first
`define MMIO_LY3_IP0            7'h34   // Four bytes LSB first
`define MMIO_DIAG_SCRATCH0      7'h70   // Four scratch bytes
`define MMIO_DIAG_CTRL          7'h74   // Loopback enables
`define MMIO_PAGE_SEL           7'h7F   // Upper page select

// Reset defaults
`define MMIO_DEF_VPD_ID         8'h3D   // Variant with memory
`define MMIO_DEF_VPD_VER        8'h01
`define MMIO_DEF_VPD_REV        8'h00
`define MMIO_DEF_ETH0_0         8'h41   // RxEq on and swing 4
`define MMIO_DEF_ETH0_1         8'h05
`define MMIO_DEF_ETH0_2         8'h05
`define MMIO_DEF_SCRATCH0       8'hDE
`define MMIO_DEF_SCRATCH1       8'hAD
`define MMIO_DEF_SCRATCH2       8'hBE
`define MMIO_DEF_SCRATCH3       8'hEF

// Field positions in the stored vectors
`define MMIO_ETH0_RXEQ_BIT      0
`define MMIO_ETH0_SWING_LSB     4
`define MMIO_ETH0_PRE_LSB       8       // Low 5 bits of byte 1
`define MMIO_ETH0_POST_LSB      16      // Low 5 bits of byte 2
`define MMIO_DIAG_PCS_LOOP_BIT  0
`define MMIO_DIAG_MAC_LOOP_BIT  1
`define MMIO_DIAG_MAC_SWAP_BIT  2

// ------------------------------
// Paged memory
// ------------------------------
`define MMIO_RAM_BYTES          2048
`define MMIO_RAM_PAGE_BITS      4       // Page bits actually decoded

`endif

/* verilog/emifBusPkg.sv */
package emifBusPkg;

  // ------------------------------
  // Processor bus side
  // ------------------------------
  typedef logic [7:0]  emifAddrT;   // Full bus address
  typedef logic [6:0]  emifOffsT;   // Byte within a 128-byte page
  typedef logic [7:0]  emifDataT;   // Bus data byte

  // Page register value, only low bits decode
  typedef logic [7:0]  pageSelT;

  // ------------------------------
  // Dual-port memory side
  // ------------------------------
  // Byte address is page bits over the offset
  typedef logic [10:0] dpramAddrT;

  typedef logic [8:0]  xmemAddrT;   // Fabric word address
  typedef logic [31:0] xmemDataT;   // Fabric word, byte 0 in bits 7:0

endpackage

/* verilog/shellCfgPkg.sv */
package shellCfgPkg;

  // ------------------------------
  // Network identity
  // ------------------------------
  // Assembled from the LY2_MAC bytes, byte 0 lowest
  typedef logic [47:0] macAddrT;

  // Assembled from the LY3_IP bytes, byte 0 lowest
  typedef logic [31:0] ipAddrT;

  // ------------------------------
  // ETH0 transceiver tuning
  // ------------------------------
  typedef logic [3:0]  txSwingT;    // Driver swing code

  // Pre- and post-cursor emphasis
  typedef logic [4:0]  txCursorT;

  // Loopback and swap enables stay single bits

endpackage

/* verilog/mmioRegFile.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioRegFile
(
  input  logic                   piShlClk,
  input  logic                   rstN,
  input  logic                   wrEn,
  input  logic                   rdEn,
  input  emifBusPkg::emifOffsT   offset,
  input  emifBusPkg::emifDataT   wrData,
  input  logic                   mc0CalDone,
  input  logic                   mc1CalDone,
  input  logic                   eth0CoreReady,
  input  logic                   eth0QpllLock,
  output emifBusPkg::emifDataT   rdData,
  output emifBusPkg::pageSelT    pageSel,
  output logic                   eth0RxEqMode,
  output shellCfgPkg::txSwingT   eth0TxSwing,
  output shellCfgPkg::txCursorT  eth0TxPreCursor,
  output shellCfgPkg::txCursorT  eth0TxPostCursor,
  output logic                   eth0PcsLoopEn,
  output logic                   eth0MacLoopEn,
  output logic                   eth0MacSwapEn,
  output shellCfgPkg::macAddrT   macAddress,
  output shellCfgPkg::ipAddrT    ipAddress
);

  emifBusPkg::emifDataT  vpdId;
  emifBusPkg::emifDataT  vpdVer;
  emifBusPkg::emifDataT  vpdRev;
  logic [23:0]           eth0Reg;     // ETH0 bytes 2..0
  shellCfgPkg::macAddrT  macReg;
  shellCfgPkg::ipAddrT   ipReg;
  logic [31:0]           scratchReg;  // Scratch bytes 3..0
  emifBusPkg::emifDataT  diagCtrl;
  emifBusPkg::pageSelT   pageReg;
  emifBusPkg::emifDataT  phyStat;
  emifBusPkg::emifDataT  rdNext;

  // Live status, upper nibble reads zero
  assign phyStat = {4'b0000, eth0QpllLock, eth0CoreReady, mc1CalDone, mc0CalDone};

  // ------------------------------
  // Write path
  // ------------------------------
  always_ff @(posedge piShlClk)
  begin
    if (!rstN)
    begin
      vpdId      <= `MMIO_DEF_VPD_ID;
      vpdVer     <= `MMIO_DEF_VPD_VER;
      vpdRev     <= `MMIO_DEF_VPD_REV;
      eth0Reg    <= {`MMIO_DEF_ETH0_2, `MMIO_DEF_ETH0_1, `MMIO_DEF_ETH0_0};
      macReg     <= '0;
      ipReg      <= '0;
      scratchReg <= {`MMIO_DEF_SCRATCH3, `MMIO_DEF_SCRATCH2,
                     `MMIO_DEF_SCRATCH1, `MMIO_DEF_SCRATCH0};
      diagCtrl   <= '0;
      pageReg    <= '0;
    end
    else if (wrEn)
    begin
      case (offset)
        `MMIO_CFG_VPD_ID:  vpdId    <= wrData;
        `MMIO_CFG_VPD_VER: vpdVer   <= wrData;
        `MMIO_CFG_VPD_REV: vpdRev   <= wrData;
        `MMIO_DIAG_CTRL:   diagCtrl <= wrData;
        `MMIO_PAGE_SEL:    pageReg  <= wrData;
        default: ;                              // PHY_STAT and holes ignore writes
      endcase
      // Multi-byte fields, one lane per offset
      for (int i = 0; i < 3; i++)
      begin
        if (offset == `MMIO_PHY_ETH0 + i)
          eth0Reg[8*i +: 8] <= wrData;
      end
      for (int i = 0; i < 6; i++)
      begin
        if (offset == `MMIO_LY2_MAC0 + i)
          macReg[8*i +: 8] <= wrData;
      end
      for (int i = 0; i < 4; i++)
      begin
        if (offset == `MMIO_LY3_IP0 + i)
          ipReg[8*i +: 8] <= wrData;
        if (offset == `MMIO_DIAG_SCRATCH0 + i)
          scratchReg[8*i +: 8] <= wrData;
      end
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb
  begin
    rdNext = '0;  // Unmapped bytes read zero
    case (offset)
      `MMIO_CFG_VPD_ID:  rdNext = vpdId;
      `MMIO_CFG_VPD_VER: rdNext = vpdVer;
      `MMIO_CFG_VPD_REV: rdNext = vpdRev;
      `MMIO_PHY_STAT:    rdNext = phyStat;
      `MMIO_DIAG_CTRL:   rdNext = diagCtrl;
      `MMIO_PAGE_SEL:    rdNext = pageReg;
      default: ;
    endcase
    for (int i = 0; i < 3; i++)
    begin
      if (offset == `MMIO_PHY_ETH0 + i)
        rdNext = eth0Reg[8*i +: 8];
    end
    for (int i = 0; i < 6; i++)
    begin
      if (offset == `MMIO_LY2_MAC0 + i)
        rdNext = macReg[8*i +: 8];
    end
    for (int i = 0; i < 4; i++)
    begin
      if (offset == `MMIO_LY3_IP0 + i)
        rdNext = ipReg[8*i +: 8];
      if (offset == `MMIO_DIAG_SCRATCH0 + i)
        rdNext = scratchReg[8*i +: 8];
    end
  end

  // Captured at the request edge, decoder picks it up next cycle
  always_ff @(posedge piShlClk)
  begin
    if (rdEn)
      rdData <= rdNext;
  end

  // Field outputs
  assign eth0RxEqMode     = eth0Reg[`MMIO_ETH0_RXEQ_BIT];
  assign eth0TxSwing      = eth0Reg[`MMIO_ETH0_SWING_LSB +: 4];
  assign eth0TxPreCursor  = eth0Reg[`MMIO_ETH0_PRE_LSB +: 5];
  assign eth0TxPostCursor = eth0Reg[`MMIO_ETH0_POST_LSB +: 5];
  assign eth0PcsLoopEn    = diagCtrl[`MMIO_DIAG_PCS_LOOP_BIT];
  assign eth0MacLoopEn    = diagCtrl[`MMIO_DIAG_MAC_LOOP_BIT];
  assign eth0MacSwapEn    = diagCtrl[`MMIO_DIAG_MAC_SWAP_BIT];
  assign macAddress       = macReg;
  assign ipAddress        = ipReg;
  assign pageSel          = pageReg;    // To the paged memory

endmodule

/* verilog/mmioPageRam.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioPageRam
(
  input  logic                  piShlClk,
  input  logic                  rstN,
  // Paged byte port
  input  logic                  wrEn,
  input  logic                  rdEn,
  input  emifBusPkg::emifOffsT  offset,
  input  emifBusPkg::pageSelT   pageSel,
  input  emifBusPkg::emifDataT  wrData,
  output emifBusPkg::emifDataT  rdData,
  // Fabric word port
  input  logic                  xmemEn,
  input  logic                  xmemWrEn,
  input  emifBusPkg::xmemAddrT  xmemAddr,
  input  emifBusPkg::xmemDataT  xmemWrData,
  output emifBusPkg::xmemDataT  xmemRdData
);

  localparam int cWords = `MMIO_RAM_BYTES / 4;

  emifBusPkg::xmemDataT  mem [0:cWords-1];   // 512 x 32
  emifBusPkg::dpramAddrT byteAddr;
  emifBusPkg::xmemAddrT  wordAddr;
  logic [1:0]            lane;

  // Page bits above the offset
  assign byteAddr = {pageSel[`MMIO_RAM_PAGE_BITS-1:0], offset};
  assign wordAddr = byteAddr[10:2];
  assign lane     = byteAddr[1:0];         // Byte 4w sits in bits 7:0

  // ------------------------------
  // Writes from both ports
  // ------------------------------
  always_ff @(posedge piShlClk)
  begin
    if (xmemEn && xmemWrEn)
      mem[xmemAddr] <= xmemWrData;         // Whole word
    if (wrEn)
      mem[wordAddr][8*lane +: 8] <= wrData;  // Single lane
  end

  // Bus read, one lane of the word
  always_ff @(posedge piShlClk)
  begin
    if (rdEn)
      rdData <= mem[wordAddr][8*lane +: 8];
  end

  // Fabric read, holds between reads
  always_ff @(posedge piShlClk)
  begin
    if (!rstN)
      xmemRdData <= '0;
    else if (xmemEn && !xmemWrEn)
      xmemRdData <= mem[xmemAddr];
  end

endmodule

/* verilog/mmioBusDecode.sv */
`timescale 1ns/1ps

module mmioBusDecode
(
  input  logic                  piShlClk,
  input  logic                  rstN,
  input  logic                  csN,
  input  logic                  weN,
  input  logic                  addrHigh,    // 0 regs, 1 memory
  input  emifBusPkg::emifDataT  regRdData,
  input  emifBusPkg::emifDataT  ramRdData,
  output logic                  regWrEn,
  output logic                  regRdEn,
  output logic                  ramWrEn,
  output logic                  ramRdEn,
  output emifBusPkg::emifDataT  dataOut
);

  logic busWr;
  logic busRd;
  logic rdPend;      // Read issued last cycle
  logic bankSel;     // Its bank, aligned with the read bytes

  // ------------------------------
  // Strobe decode
  // ------------------------------
  assign busWr = !csN && !weN;
  assign busRd = !csN && weN;

  assign regWrEn = busWr && !addrHigh;
  assign regRdEn = busRd && !addrHigh;
  assign ramWrEn = busWr && addrHigh;
  assign ramRdEn = busRd && addrHigh;

  // ------------------------------
  // Read return
  // ------------------------------
  always_ff @(posedge piShlClk)
  begin
    if (!rstN)
    begin
      rdPend  <= 1'b0;
      bankSel <= 1'b0;
      dataOut <= '0;
    end
    else
    begin
      rdPend  <= busRd;
      bankSel <= addrHigh;
      if (rdPend)
        dataOut <= bankSel ? ramRdData : regRdData;  // Otherwise hold
    end
  end

endmodule

/* verilog/MmioClient.sv */
`timescale 1ns/1ps

module MmioClient
(
  input  logic                   piShlClk,
  input  logic                   rstN,
  // Processor bus
  input  logic                   csN,
  input  logic                   weN,
  input  emifBusPkg::emifAddrT   addr,
  input  emifBusPkg::emifDataT   dataIn,
  output emifBusPkg::emifDataT   dataOut,
  // Status inputs
  input  logic                   mc0CalDone,
  input  logic                   mc1CalDone,
  input  logic                   eth0CoreReady,
  input  logic                   eth0QpllLock,
  // Control outputs
  output logic                   eth0RxEqMode,
  output shellCfgPkg::txSwingT   eth0TxSwing,
  output shellCfgPkg::txCursorT  eth0TxPreCursor,
  output shellCfgPkg::txCursorT  eth0TxPostCursor,
  output logic                   eth0PcsLoopEn,
  output logic                   eth0MacLoopEn,
  output logic                   eth0MacSwapEn,
  output shellCfgPkg::macAddrT   macAddress,
  output shellCfgPkg::ipAddrT    ipAddress,
  // Fabric memory port
  input  logic                   xmemEn,
  input  logic                   xmemWrEn,
  input  emifBusPkg::xmemAddrT   xmemAddr,
  input  emifBusPkg::xmemDataT   xmemWrData,
  output emifBusPkg::xmemDataT   xmemRdData
);

  logic                  addrHigh;
  emifBusPkg::emifOffsT  offset;
  logic                  regWrEn;
  logic                  regRdEn;
  logic                  ramWrEn;
  logic                  ramRdEn;
  emifBusPkg::emifDataT  regRdData;
  emifBusPkg::emifDataT  ramRdData;
  emifBusPkg::pageSelT   pageSel;

  assign addrHigh = addr[7];     // Bank select
  assign offset   = addr[6:0];

  mmioBusDecode busDecode
  (
    .piShlClk  (piShlClk),
    .rstN      (rstN),
    .csN       (csN),
    .weN       (weN),
    .addrHigh  (addrHigh),
    .regRdData (regRdData),
    .ramRdData (ramRdData),
    .regWrEn   (regWrEn),
    .regRdEn   (regRdEn),
    .ramWrEn   (ramWrEn),
    .ramRdEn   (ramRdEn),
    .dataOut   (dataOut)
  );

  // Control and status bytes 00h..7Fh
  mmioRegFile regFile
  (
    .piShlClk         (piShlClk),
    .rstN             (rstN),
    .wrEn             (regWrEn),
    .rdEn             (regRdEn),
    .offset           (offset),
    .wrData           (dataIn),
    .mc0CalDone       (mc0CalDone),
    .mc1CalDone       (mc1CalDone),
    .eth0CoreReady    (eth0CoreReady),
    .eth0QpllLock     (eth0QpllLock),
    .rdData           (regRdData),
    .pageSel          (pageSel),
    .eth0RxEqMode     (eth0RxEqMode),
    .eth0TxSwing      (eth0TxSwing),
    .eth0TxPreCursor  (eth0TxPreCursor),
    .eth0TxPostCursor (eth0TxPostCursor),
    .eth0PcsLoopEn    (eth0PcsLoopEn),
    .eth0MacLoopEn    (eth0MacLoopEn),
    .eth0MacSwapEn    (eth0MacSwapEn),
    .macAddress       (macAddress),
    .ipAddress        (ipAddress)
  );

  // Paged window 80h..FFh
  mmioPageRam pageRam
  (
    .piShlClk   (piShlClk),
    .rstN       (rstN),
    .wrEn       (ramWrEn),
    .rdEn       (ramRdEn),
    .offset     (offset),
    .pageSel    (pageSel),
    .wrData     (dataIn),
    .rdData     (ramRdData),
    .xmemEn     (xmemEn),
    .xmemWrEn   (xmemWrEn),
    .xmemAddr   (xmemAddr),
    .xmemWrData (xmemWrData),
    .xmemRdData (xmemRdData)
  );

endmodule

/* test/mmioClient_checker.sv */
`timescale 1ns/1ps

module mmioClient_checker
(
  input  logic                  piShlClk,
  input  logic                  rstN,
  input  logic                  csN,
  input  logic                  regWrEn,
  input  logic                  regRdEn,
  input  logic                  ramWrEn,
  input  logic                  ramRdEn,
  input  emifBusPkg::emifDataT  dataOut
);

  int   assertFails = 0;   // Assertion failure count
  logic anyStrobe;

  assign anyStrobe = regWrEn || regRdEn || ramWrEn || ramRdEn;

  // ------------------------------
  // Decoder strobes
  // ------------------------------
  wrExclusive: assert property (@(posedge piShlClk) disable iff (!rstN)
    !(regWrEn && ramWrEn))
    else
    begin
      $error("regWrEn and ramWrEn high together");
      assertFails++;
    end

  idleNoStrobe: assert property (@(posedge piShlClk) disable iff (!rstN)
    csN |-> !anyStrobe)
    else
    begin
      $error("Strobe high while csN is high");
      assertFails++;
    end

  // dataOut moves only two edges after a read strobe
  holdData: assert property (@(posedge piShlClk) disable iff (!rstN)
    ($past(rstN) && !$past(regRdEn || ramRdEn, 2)) |-> $stable(dataOut))
    else
    begin
      $error("dataOut changed without a read");
      assertFails++;
    end

endmodule

bind mmioBusDecode mmioClient_checker busChecker
(
  .piShlClk (piShlClk),
  .rstN     (rstN),
  .csN      (csN),
  .regWrEn  (regWrEn),
  .regRdEn  (regRdEn),
  .ramWrEn  (ramWrEn),
  .ramRdEn  (ramRdEn),
  .dataOut  (dataOut)
);

/* test/mmioClient_tb.sv */
`timescale 1ns/1ps
`include "mmio_params.svh"

module mmioClient_tb;

  localparam int maxCycles = 2000;   // Tests need a few hundred cycles

  logic                    piShlClk;
  logic                    rstN;
  logic                    csN;
  logic                    weN;
  emifBusPkg::emifAddrT    addr;
  emifBusPkg::emifDataT    dataIn;
  emifBusPkg::emifDataT    dataOut;
  logic                    mc0CalDone;
  logic                    mc1CalDone;
  logic                    eth0CoreReady;
  logic                    eth0QpllLock;
  logic                    eth0RxEqMode;
  shellCfgPkg::txSwingT    eth0TxSwing;
  shellCfgPkg::txCursorT   eth0TxPreCursor;
  shellCfgPkg::txCursorT   eth0TxPostCursor;
  logic                    eth0PcsLoopEn;
  logic                    eth0MacLoopEn;
  logic                    eth0MacSwapEn;
  shellCfgPkg::macAddrT    macAddress;
  shellCfgPkg::ipAddrT     ipAddress;
  logic                    xmemEn;
  logic                    xmemWrEn;
  emifBusPkg::xmemAddrT    xmemAddr;
  emifBusPkg::xmemDataT    xmemWrData;
  emifBusPkg::xmemDataT    xmemRdData;

  int                      seed = 50937;
  int                      cycleCount = 0;

  MmioClient i_dut
  (
    .piShlClk (piShlClk), .rstN (rstN), .csN (csN), .weN (weN), .addr (addr),
    .dataIn (dataIn), .dataOut (dataOut), .mc0CalDone (mc0CalDone),
    .mc1CalDone (mc1CalDone), .eth0CoreReady (eth0CoreReady),
    .eth0QpllLock (eth0QpllLock), .eth0RxEqMode (eth0RxEqMode),
    .eth0TxSwing (eth0TxSwing), .eth0TxPreCursor (eth0TxPreCursor),
    .eth0TxPostCursor (eth0TxPostCursor), .eth0PcsLoopEn (eth0PcsLoopEn),
    .eth0MacLoopEn (eth0MacLoopEn), .eth0MacSwapEn (eth0MacSwapEn),
    .macAddress (macAddress), .ipAddress (ipAddress), .xmemEn (xmemEn),
    .xmemWrEn (xmemWrEn), .xmemAddr (xmemAddr), .xmemWrData (xmemWrData),
    .xmemRdData (xmemRdData)
  );

  initial
  begin
    piShlClk = 1'b0;
    forever #50 piShlClk = ~piShlClk;   // 100 ns period
  end

  // Run limit
  always @(posedge piShlClk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= maxCycles)
    begin
      $display("Timeout after %0d cycles, tests did not finish", maxCycles);
      $display("Errors found");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  // Bound decoder assertions
  always @(posedge piShlClk)
  begin
    if (i_dut.busDecode.busChecker.assertFails != 0)
    begin
      $display("A bus decoder assertion failed");
      $display("Errors found");
      $fatal(1, "Assertion failure");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic checkValue(input string name, input logic [47:0] actual,
                            input logic [47:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL %s: actual %h expected %h", name, actual, expected);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic busWrite(input emifBusPkg::emifAddrT a, input emifBusPkg::emifDataT d);
    @(posedge piShlClk);
    csN    <= 1'b0;
    weN    <= 1'b0;
    addr   <= a;
    dataIn <= d;
    @(posedge piShlClk);   // Write lands here
    csN    <= 1'b1;
    weN    <= 1'b1;
  endtask

  task automatic busRead(input emifBusPkg::emifAddrT a, input emifBusPkg::emifDataT expected);
    @(posedge piShlClk);
    csN  <= 1'b0;
    weN  <= 1'b1;
    addr <= a;
    @(posedge piShlClk);   // Request edge
    csN  <= 1'b1;
    @(posedge piShlClk);   // dataOut loads
    @(negedge piShlClk);
    checkValue($sformatf("dataOut[%h]", a), dataOut, expected);
  endtask

  // Two reads on consecutive edges
  task automatic busReadPair(input emifBusPkg::emifAddrT a0, input emifBusPkg::emifDataT e0,
                             input emifBusPkg::emifAddrT a1, input emifBusPkg::emifDataT e1);
    @(posedge piShlClk);
    csN  <= 1'b0;
    weN  <= 1'b1;
    addr <= a0;
    @(posedge piShlClk);
    addr <= a1;
    @(posedge piShlClk);
    csN  <= 1'b1;
    @(negedge piShlClk);
    checkValue($sformatf("dataOut[%h]", a0), dataOut, e0);
    @(negedge piShlClk);
    checkValue($sformatf("dataOut[%h]", a1), dataOut, e1);
  endtask

  task automatic xmemWrite(input emifBusPkg::xmemAddrT w, input emifBusPkg::xmemDataT d);
    @(posedge piShlClk);
    xmemEn     <= 1'b1;
    xmemWrEn   <= 1'b1;
    xmemAddr   <= w;
    xmemWrData <= d;
    @(posedge piShlClk);
    xmemEn     <= 1'b0;
    xmemWrEn   <= 1'b0;
  endtask

  task automatic xmemRead(input emifBusPkg::xmemAddrT w, input emifBusPkg::xmemDataT expected);
    @(posedge piShlClk);
    xmemEn   <= 1'b1;
    xmemWrEn <= 1'b0;
    xmemAddr <= w;
    @(posedge piShlClk);   // Word registered here
    xmemEn   <= 1'b0;
    @(negedge piShlClk);
    checkValue("xmemRdData", xmemRdData, expected);
  endtask

  task automatic setStatus(input logic [3:0] s);
    @(posedge piShlClk);
    mc0CalDone    <= s[0];
    mc1CalDone    <= s[1];
    eth0CoreReady <= s[2];
    eth0QpllLock  <= s[3];
  endtask

  task automatic checkControls(input logic rxEq, input logic [3:0] swing,
                               input logic [4:0] pre, input logic [4:0] post,
                               input logic [2:0] loops, input logic [47:0] mac,
                               input logic [31:0] ip);
    @(negedge piShlClk);
    checkValue("eth0RxEqMode", eth0RxEqMode, rxEq);
    checkValue("eth0TxSwing", eth0TxSwing, swing);
    checkValue("eth0TxPreCursor", eth0TxPreCursor, pre);
    checkValue("eth0TxPostCursor", eth0TxPostCursor, post);
    checkValue("eth0PcsLoopEn", eth0PcsLoopEn, loops[0]);
    checkValue("eth0MacLoopEn", eth0MacLoopEn, loops[1]);
    checkValue("eth0MacSwapEn", eth0MacSwapEn, loops[2]);
    checkValue("macAddress", macAddress, mac);
    checkValue("ipAddress", ipAddress, ip);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic resetDefaults();
    checkControls(1'b1, 4'h4, 5'h05, 5'h05, 3'b000, 48'h0, 32'h0);
    busRead(`MMIO_CFG_VPD_ID, 8'h3D);
    busRead(`MMIO_CFG_VPD_VER, 8'h01);
    busRead(`MMIO_CFG_VPD_REV, 8'h00);
    busRead(`MMIO_DIAG_SCRATCH0, 8'hDE);
    busRead(`MMIO_DIAG_SCRATCH0 + 1, 8'hAD);
    busRead(`MMIO_DIAG_SCRATCH0 + 2, 8'hBE);
    busRead(`MMIO_DIAG_SCRATCH0 + 3, 8'hEF);
  endtask

  task automatic controlWrites();
    logic [47:0] mac;
    logic [31:0] ip;
    mac = 48'h665544332211;
    ip  = 32'h0A01A8C0;          // 192.168.1.10 sent LSB first
    for (int i = 0; i < 6; i++)
      busWrite(`MMIO_LY2_MAC0 + i, mac[8*i +: 8]);
    for (int i = 0; i < 4; i++)
      busWrite(`MMIO_LY3_IP0 + i, ip[8*i +: 8]);
    busWrite(`MMIO_PHY_ETH0, 8'hA0);       // RxEq off and swing Ah
    busWrite(`MMIO_PHY_ETH0 + 1, 8'hF3);   // Upper bits dropped from cursor
    busWrite(`MMIO_PHY_ETH0 + 2, 8'h1E);
    busWrite(`MMIO_DIAG_CTRL, 8'h05);      // PCS loop and MAC swap
    checkControls(1'b0, 4'hA, 5'h13, 5'h1E, 3'b101, mac, ip);
    for (int i = 0; i < 6; i++)
      busRead(`MMIO_LY2_MAC0 + i, mac[8*i +: 8]);
    for (int i = 0; i < 4; i++)
      busRead(`MMIO_LY3_IP0 + i, ip[8*i +: 8]);
    busRead(`MMIO_PHY_ETH0, 8'hA0);
    busRead(`MMIO_PHY_ETH0 + 1, 8'hF3);
    busRead(`MMIO_PHY_ETH0 + 2, 8'h1E);
    busRead(`MMIO_DIAG_CTRL, 8'h05);
  endtask

  task automatic readOnlyAndUnmapped();
    logic [3:0] stat;
    logic [7:0] val;
    for (int i = 0; i < 4; i++)
    begin
      stat = $random(seed);
      setStatus(stat);
      busWrite(`MMIO_PHY_STAT, 8'hFF);     // Ignored
      busRead(`MMIO_PHY_STAT, {4'h0, stat});
    end
    busWrite(8'h21, 8'h5A);
    busRead(8'h21, 8'h00);
    busWrite(8'h50, 8'hA5);
    busRead(8'h50, 8'h00);
    for (int i = 0; i < 4; i++)
    begin
      val = $random(seed);
      busWrite(`MMIO_DIAG_SCRATCH0 + i, val);
      busRead(`MMIO_DIAG_SCRATCH0 + i, val);
    end
  endtask

  task automatic busToFabric();
    busWrite(`MMIO_PAGE_SEL, 8'd3);
    busWrite(8'h80 + 8, 8'h12);
    busWrite(8'h80 + 9, 8'h34);
    busWrite(8'h80 + 10, 8'h56);
    busWrite(8'h80 + 11, 8'h78);
    xmemRead(3 * 32 + 2, 32'h78563412);    // Byte 8 lands in bits 7:0
  endtask

  task automatic fabricToBus();
    logic [31:0] word;
    word = $random(seed);
    xmemWrite(12 * 32 + 10, word);         // Offsets 40..43 of page 12
    busWrite(`MMIO_PAGE_SEL, 8'd12);
    for (int i = 0; i < 4; i++)
      busRead(8'h80 + 40 + i, word[8*i +: 8]);
    busWrite(`MMIO_PAGE_SEL, 8'd28);       // Same low nibble
    busRead(`MMIO_PAGE_SEL, 8'd28);
    busReadPair(8'h80 + 40, word[7:0], 8'h80 + 41, word[15:8]);
    busReadPair(8'h80 + 42, word[23:16], 8'h80 + 43, word[31:24]);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    rstN          = 1'b0;
    csN           = 1'b1;
    weN           = 1'b1;
    addr          = '0;
    dataIn        = '0;
    mc0CalDone    = 1'b0;
    mc1CalDone    = 1'b0;
    eth0CoreReady = 1'b0;
    eth0QpllLock  = 1'b0;
    xmemEn        = 1'b0;
    xmemWrEn      = 1'b0;
    xmemAddr      = '0;
    xmemWrData    = '0;
    repeat (2) @(posedge piShlClk);
    rstN <= 1'b1;
    resetDefaults();
    controlWrites();
    readOnlyAndUnmapped();
    busToFabric();
    fabricToBus();
    repeat (3) @(posedge piShlClk);   // Let the last assertions settle
    if (i_dut.busDecode.busChecker.assertFails == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
    begin
      $display("Bus decoder assertions failed %0d times",
               i_dut.busDecode.busChecker.assertFails);
      $display("Errors found");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/emifBusPkg.sv
verilog/shellCfgPkg.sv
verilog/mmioRegFile.sv
verilog/mmioPageRam.sv
verilog/mmioBusDecode.sv
verilog/MmioClient.sv
test/mmioClient_checker.sv
test/mmioClient_tb.sv
